// ==== flist.f ====
+incdir+verilog
verilog/axi_pkg.sv
verilog/sys_bus_pkg.sv
verilog/axi_slave.sv
verilog/sys_bus_decoder.sv
verilog/sys_reg_bank.sv
verilog/ps_axi_sys.sv
tb/ps_axi_sys_sva.sv
tb/ps_axi_sys_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, verdict from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module ps_axi_sys_tb \
  -o sim > build.log 2>&1 \
  && ./obj_dir/sim > sim.log 2>&1
grep -q "^No errors$" sim.log && echo "PASS" && exit 0 || echo "FAIL" && exit 1

// ==== tb/ps_axi_sys_tb.sv ====
//////////////////////////////////////////////////////////////////////
// plays the axi gp master against the bridge and both banks
// one transfer at a time
// stops at the first mismatch
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ps_bus_macros.svh"

module ps_axi_sys_tb;

  localparam int TMO = 50;  // cycles allowed per wait

  logic clk = 1'b0;
  logic rst;
  axi_pkg::axi_id_t   awid, arid, bid, rid;
  axi_pkg::axi_addr_t awaddr, araddr;
  axi_pkg::axi_len_t  awlen, arlen;
  axi_pkg::axi_data_t wdata, rdata;
  axi_pkg::axi_strb_t wstrb;
  axi_pkg::axi_resp_e bresp, rresp;
  logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rlast, rvalid, rready;

  axi_pkg::axi_data_t bank_a_m [`SYS_BANK_A_REGS];  // model memories
  axi_pkg::axi_data_t bank_b_m [`SYS_BANK_B_REGS];
  integer seed = 55;

  always #5 clk = ~clk;

  ps_axi_sys u_dut (
    .clk_i (clk), .rst_i (rst),
    .axi_awid_i (awid), .axi_awaddr_i (awaddr), .axi_awlen_i (awlen),
    .axi_awvalid_i (awvalid), .axi_awready_o (awready),
    .axi_wdata_i (wdata), .axi_wstrb_i (wstrb), .axi_wlast_i (wlast),
    .axi_wvalid_i (wvalid), .axi_wready_o (wready),
    .axi_bid_o (bid), .axi_bresp_o (bresp), .axi_bvalid_o (bvalid), .axi_bready_i (bready),
    .axi_arid_i (arid), .axi_araddr_i (araddr), .axi_arlen_i (arlen),
    .axi_arvalid_i (arvalid), .axi_arready_o (arready),
    .axi_rid_o (rid), .axi_rdata_o (rdata), .axi_rresp_o (rresp), .axi_rlast_o (rlast),
    .axi_rvalid_o (rvalid), .axi_rready_i (rready)
  );

  bind axi_slave ps_axi_sys_sva u_sva (.*);

  task automatic abort_run(input string what);
    $display("%s at %0t", what, $time);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_resp(input string name, input axi_pkg::axi_resp_e got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_data(input string name, input axi_pkg::axi_data_t got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_id(input string name, input axi_pkg::axi_id_t got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_cycles(input string name, input int got, exp);
    if (got != exp) begin
      $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // expected response and read word from the address map and the model
  function automatic axi_pkg::axi_resp_e ref_access(input axi_pkg::axi_addr_t addr,
                                                    output axi_pkg::axi_data_t data);
    logic [11:0] region;
    int unsigned idx;
    region = addr[31:`SYS_REGION_LSB];
    idx    = 32'(addr[`SYS_REGION_LSB-1:2]);
    data   = '0;
    if (region == `SYS_BANK_A_REGION && idx < `SYS_BANK_A_REGS) begin
      data = bank_a_m[idx];
      return axi_pkg::OKAY;
    end
    if (region == `SYS_BANK_B_REGION && idx < `SYS_BANK_B_REGS) begin
      data = bank_b_m[idx];
      return axi_pkg::OKAY;
    end
    return axi_pkg::SLVERR;  // out of range or hole in the map
  endfunction

  function automatic axi_pkg::axi_data_t merge(input axi_pkg::axi_data_t old_w, new_w,
                                               input axi_pkg::axi_strb_t strb);
    axi_pkg::axi_data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // waits for response valid and checks its cycle offset from the acceptance cycle
  task automatic wait_resp(input bit is_wr);
    int lat;
    lat = 1;  // first cycle after the acceptance edge
    @(negedge clk);
    while (!(is_wr ? bvalid : rvalid)) begin
      if (lat == TMO) abort_run("timeout waiting for response valid");
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    check_cycles("latency", lat, 3);
  endtask

  task automatic axi_write(input axi_pkg::axi_id_t id, input axi_pkg::axi_addr_t addr,
                           input axi_pkg::axi_data_t data, input axi_pkg::axi_strb_t strb,
                           input int hold);
    axi_pkg::axi_resp_e exp;
    axi_pkg::axi_data_t old_w;
    int n;
    n = 0;
    exp = ref_access(addr, old_w);
    @(posedge clk);
    awid    <= id;
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    wlast   <= 1'b1;
    @(negedge clk);
    while (!(awready && wready)) begin
      if (n == TMO) abort_run("timeout waiting for awready and wready");
      @(negedge clk);
      n++;
    end
    @(posedge clk);  // acceptance edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    wait_resp(1'b1);
    check_resp("bresp", bresp, exp);
    check_id("bid", bid, id);
    for (int k = 0; k < hold; k++) begin
      @(posedge clk);
      arvalid <= 1'b1;  // offered read must wait
      @(negedge clk);
      if (!bvalid) abort_run("bvalid dropped while bready low");
      check_resp("bresp", bresp, exp);
      check_id("bid", bid, id);
      if (awready || wready || arready) abort_run("address accepted while response held");
    end
    @(posedge clk);
    bready  <= 1'b1;
    arvalid <= 1'b0;
    @(posedge clk);
    bready <= 1'b0;
    if (exp == axi_pkg::OKAY) begin
      if (addr[31:`SYS_REGION_LSB] == `SYS_BANK_A_REGION)
        bank_a_m[addr[3:2]] = merge(old_w, data, strb);
      else
        bank_b_m[addr[5:2]] = merge(old_w, data, strb);
    end
  endtask

  task automatic axi_read(input axi_pkg::axi_id_t id, input axi_pkg::axi_addr_t addr,
                          input int hold);
    axi_pkg::axi_resp_e exp;
    axi_pkg::axi_data_t exp_d;
    int n;
    n = 0;
    exp = ref_access(addr, exp_d);
    @(posedge clk);
    arid    <= id;
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready) begin
      if (n == TMO) abort_run("timeout waiting for arready");
      @(negedge clk);
      n++;
    end
    @(posedge clk);
    arvalid <= 1'b0;
    wait_resp(1'b0);
    for (int k = 0; k <= hold; k++) begin
      if (k > 0) begin
        @(posedge clk);
        awvalid <= 1'b1;  // offered write must wait
        wvalid  <= 1'b1;
        @(negedge clk);
        if (!rvalid) abort_run("rvalid dropped while rready low");
        if (awready || wready || arready) abort_run("address accepted while response held");
      end
      check_resp("rresp", rresp, exp);
      check_id("rid", rid, id);
      if (!rlast) abort_run("rlast low on a read response");
      if (exp == axi_pkg::OKAY) check_data("rdata", rdata, exp_d);
    end
    @(posedge clk);
    rready  <= 1'b1;
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic read_all;
    for (int i = 0; i < `SYS_BANK_A_REGS; i++)
      axi_read(axi_pkg::axi_id_t'($random(seed)), 32'h4000_0000 + 32'(i * 4), 0);
    for (int i = 0; i < `SYS_BANK_B_REGS; i++)
      axi_read(axi_pkg::axi_id_t'($random(seed)), 32'h4010_0000 + 32'(i * 4), 0);
  endtask

  initial begin
    rst     = 1'b1;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < `SYS_BANK_A_REGS; i++) bank_a_m[i] = '0;
    for (int i = 0; i < `SYS_BANK_B_REGS; i++) bank_b_m[i] = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    ////////////////////////////////////////////////////////////////////
    // reset values, full words, byte strobes
    ////////////////////////////////////////////////////////////////////
    read_all();
    for (int i = 0; i < `SYS_BANK_B_REGS; i++) begin
      axi_write(axi_pkg::axi_id_t'($random(seed)), 32'h4010_0000 + 32'(i * 4),
                axi_pkg::axi_data_t'($random(seed)), 4'hf, 0);
      if (i < `SYS_BANK_A_REGS)
        axi_write(axi_pkg::axi_id_t'($random(seed)), 32'h4000_0000 + 32'(i * 4),
                  axi_pkg::axi_data_t'($random(seed)), 4'hf, 0);
    end
    read_all();
    for (int i = 0; i < 24; i++) begin
      axi_write(axi_pkg::axi_id_t'($random(seed)),
                ((i % 2) ? 32'h4000_0000 : 32'h4010_0000) + 32'((i % 4) * 4),
                axi_pkg::axi_data_t'($random(seed)), axi_pkg::axi_strb_t'($random(seed)), 0);
    end
    read_all();

    ////////////////////////////////////////////////////////////////////
    // error paths and held responses
    ////////////////////////////////////////////////////////////////////
    axi_write(12'h0a1, 32'h4000_0010, 32'hdead_beef, 4'hf, 0);  // bank a index 4
    axi_write(12'h0a2, 32'h4010_0040, 32'hdead_beef, 4'hf, 0);  // bank b index 16
    axi_write(12'h0a3, 32'h5000_0000, 32'hdead_beef, 4'hf, 0);  // unmapped
    axi_read(12'h0b1, 32'h4000_0010, 0);
    axi_read(12'h0b2, 32'h4010_0040, 0);
    axi_read(12'h0b3, 32'h0000_0004, 0);
    read_all();
    axi_write(12'hfff, 32'h4000_0008, 32'h1234_5678, 4'h5, 3);
    axi_read(12'h800, 32'h4000_0008, 4);
    axi_read(12'h001, 32'h6000_0000, 2);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/ps_axi_sys_sva.sv ====
//////////////////////////////////////////////////////////////////////
// protocol assertions, bound to every axi_slave instance
// single-beat transfers only, response held until its ready
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ps_axi_sys_sva (
  input logic               clk_i,
  input logic               rst_i,
  input axi_pkg::axi_len_t  axi_awlen_i,
  input axi_pkg::axi_len_t  axi_arlen_i,
  input logic               axi_awvalid_i,
  input logic               axi_awready_o,
  input logic               axi_arvalid_i,
  input logic               axi_arready_o,
  input logic               axi_bvalid_o,
  input logic               axi_bready_i,
  input axi_pkg::axi_resp_e axi_bresp_o,
  input logic               axi_rvalid_o,
  input logic               axi_rready_i,
  input axi_pkg::axi_resp_e axi_rresp_o,
  input logic               sys_wen_o,
  input logic               sys_ren_o
);

  // no bursts on either address channel
  a_awlen_zero : assert property (@(posedge clk_i) disable iff (rst_i)
    (axi_awvalid_i && axi_awready_o) |-> (axi_awlen_i == '0))
    else $error("write burst length not zero");
  a_arlen_zero : assert property (@(posedge clk_i) disable iff (rst_i)
    (axi_arvalid_i && axi_arready_o) |-> (axi_arlen_i == '0))
    else $error("read burst length not zero");

  // response held and stable until taken
  a_b_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    (axi_bvalid_o && !axi_bready_i) |=> (axi_bvalid_o && $stable(axi_bresp_o)))
    else $error("bvalid dropped before bready");
  a_r_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    (axi_rvalid_o && !axi_rready_i) |=> (axi_rvalid_o && $stable(axi_rresp_o)))
    else $error("rvalid dropped before rready");

  a_one_strobe : assert property (@(posedge clk_i) !(sys_wen_o && sys_ren_o))
    else $error("write and read strobes together");

  a_rst_quiet : assert property (@(posedge clk_i) rst_i |=> (!axi_bvalid_o && !axi_rvalid_o))
    else $error("response valid during reset");

endmodule

`default_nettype wire

// ==== verilog/ps_axi_sys.sv ====
//////////////////////////////////////////////////////////////////////
// axi gp slave, region decoder and two register banks
// acceptance to bvalid or rvalid is always 3 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ps_bus_macros.svh"

module ps_axi_sys (
  input  logic               clk_i,
  input  logic               rst_i,
  // write address
  input  axi_pkg::axi_id_t   axi_awid_i,
  input  axi_pkg::axi_addr_t axi_awaddr_i,
  input  axi_pkg::axi_len_t  axi_awlen_i,
  input  logic               axi_awvalid_i,
  output logic               axi_awready_o,
  // write data
  input  axi_pkg::axi_data_t axi_wdata_i,
  input  axi_pkg::axi_strb_t axi_wstrb_i,
  input  logic               axi_wlast_i,
  input  logic               axi_wvalid_i,
  output logic               axi_wready_o,
  // write response
  output axi_pkg::axi_id_t   axi_bid_o,
  output axi_pkg::axi_resp_e axi_bresp_o,
  output logic               axi_bvalid_o,
  input  logic               axi_bready_i,
  // read address
  input  axi_pkg::axi_id_t   axi_arid_i,
  input  axi_pkg::axi_addr_t axi_araddr_i,
  input  axi_pkg::axi_len_t  axi_arlen_i,
  input  logic               axi_arvalid_i,
  output logic               axi_arready_o,
  // read data
  output axi_pkg::axi_id_t   axi_rid_o,
  output axi_pkg::axi_data_t axi_rdata_o,
  output axi_pkg::axi_resp_e axi_rresp_o,
  output logic               axi_rlast_o,
  output logic               axi_rvalid_o,
  input  logic               axi_rready_i
);

  // bridge side of the system bus
  sys_bus_pkg::sys_addr_t sys_addr;
  sys_bus_pkg::sys_data_t sys_wdata;
  sys_bus_pkg::sys_sel_t  sys_sel;
  sys_bus_pkg::sys_data_t sys_rdata;
  logic                   sys_wen;
  logic                   sys_ren;
  logic                   sys_ack;
  logic                   sys_err;

  // per bank strobes and answers
  sys_bus_pkg::sys_data_t bank_a_rdata;
  sys_bus_pkg::sys_data_t bank_b_rdata;
  logic bank_a_wen, bank_a_ren, bank_a_ack, bank_a_err;
  logic bank_b_wen, bank_b_ren, bank_b_ack, bank_b_err;

  axi_slave u_axi_slave (
    .clk_i         (clk_i        ),
    .rst_i         (rst_i        ),
    .axi_awid_i    (axi_awid_i   ),
    .axi_awaddr_i  (axi_awaddr_i ),
    .axi_awlen_i   (axi_awlen_i  ),
    .axi_awvalid_i (axi_awvalid_i),
    .axi_awready_o (axi_awready_o),
    .axi_wdata_i   (axi_wdata_i  ),
    .axi_wstrb_i   (axi_wstrb_i  ),
    .axi_wlast_i   (axi_wlast_i  ),
    .axi_wvalid_i  (axi_wvalid_i ),
    .axi_wready_o  (axi_wready_o ),
    .axi_bid_o     (axi_bid_o    ),
    .axi_bresp_o   (axi_bresp_o  ),
    .axi_bvalid_o  (axi_bvalid_o ),
    .axi_bready_i  (axi_bready_i ),
    .axi_arid_i    (axi_arid_i   ),
    .axi_araddr_i  (axi_araddr_i ),
    .axi_arlen_i   (axi_arlen_i  ),
    .axi_arvalid_i (axi_arvalid_i),
    .axi_arready_o (axi_arready_o),
    .axi_rid_o     (axi_rid_o    ),
    .axi_rdata_o   (axi_rdata_o  ),
    .axi_rresp_o   (axi_rresp_o  ),
    .axi_rlast_o   (axi_rlast_o  ),
    .axi_rvalid_o  (axi_rvalid_o ),
    .axi_rready_i  (axi_rready_i ),
    .sys_addr_o    (sys_addr     ),
    .sys_wdata_o   (sys_wdata    ),
    .sys_sel_o     (sys_sel      ),
    .sys_wen_o     (sys_wen      ),
    .sys_ren_o     (sys_ren      ),
    .sys_rdata_i   (sys_rdata    ),
    .sys_ack_i     (sys_ack      ),
    .sys_err_i     (sys_err      )
  );

  sys_bus_decoder u_decoder (
    .clk_i          (clk_i       ),
    .rst_i          (rst_i       ),
    .sys_addr_i     (sys_addr    ),
    .sys_wdata_i    (sys_wdata   ),
    .sys_sel_i      (sys_sel     ),
    .sys_wen_i      (sys_wen     ),
    .sys_ren_i      (sys_ren     ),
    .sys_rdata_o    (sys_rdata   ),
    .sys_ack_o      (sys_ack     ),
    .sys_err_o      (sys_err     ),
    .bank_a_wen_o   (bank_a_wen  ),
    .bank_a_ren_o   (bank_a_ren  ),
    .bank_a_rdata_i (bank_a_rdata),
    .bank_a_ack_i   (bank_a_ack  ),
    .bank_a_err_i   (bank_a_err  ),
    .bank_b_wen_o   (bank_b_wen  ),
    .bank_b_ren_o   (bank_b_ren  ),
    .bank_b_rdata_i (bank_b_rdata),
    .bank_b_ack_i   (bank_b_ack  ),
    .bank_b_err_i   (bank_b_err  )
  );

  // address, wdata and sel fan out to both banks
  sys_reg_bank #(
    .NUM_REGS (`SYS_BANK_A_REGS)
  ) u_bank_a (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .sys_addr_i  (sys_addr    ),
    .sys_wdata_i (sys_wdata   ),
    .sys_sel_i   (sys_sel     ),
    .sys_wen_i   (bank_a_wen  ),
    .sys_ren_i   (bank_a_ren  ),
    .sys_rdata_o (bank_a_rdata),
    .sys_ack_o   (bank_a_ack  ),
    .sys_err_o   (bank_a_err  )
  );

  sys_reg_bank #(
    .NUM_REGS (`SYS_BANK_B_REGS)
  ) u_bank_b (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .sys_addr_i  (sys_addr    ),
    .sys_wdata_i (sys_wdata   ),
    .sys_sel_i   (sys_sel     ),
    .sys_wen_i   (bank_b_wen  ),
    .sys_ren_i   (bank_b_ren  ),
    .sys_rdata_o (bank_b_rdata),
    .sys_ack_o   (bank_b_ack  ),
    .sys_err_o   (bank_b_err  )
  );

endmodule

`default_nettype wire

// ==== verilog/sys_reg_bank.sv ====
//////////////////////////////////////////////////////////////////////
// register bank on the system bus, NUM_REGS words of 32 bits
// word index is addr[SYS_REGION_LSB-1:2], region bits are ignored
// out of range index gives err and no write, NUM_REGS at least 2
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ps_bus_macros.svh"

module sys_reg_bank #(
  parameter int NUM_REGS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  sys_bus_pkg::sys_addr_t sys_addr_i,
  input  sys_bus_pkg::sys_data_t sys_wdata_i,
  input  sys_bus_pkg::sys_sel_t  sys_sel_i,
  input  logic                   sys_wen_i,
  input  logic                   sys_ren_i,
  output sys_bus_pkg::sys_data_t sys_rdata_o,
  output logic                   sys_ack_o,
  output logic                   sys_err_o
);

  localparam int IDX_W   = `SYS_REGION_LSB - 2;
  localparam int SEL_W   = $clog2(NUM_REGS);
  localparam int N_BYTES = $bits(sys_bus_pkg::sys_sel_t);

  sys_bus_pkg::sys_data_t regs_q [NUM_REGS];
  sys_bus_pkg::sys_data_t rdata_q;

  logic [IDX_W-1:0] idx;       // full word index within the region
  logic [SEL_W-1:0] word;
  logic             in_range;
  logic             access;
  logic             ack_q;
  logic             err_q;

  assign idx      = sys_addr_i[`SYS_REGION_LSB-1:2];
  assign word     = idx[SEL_W-1:0];       // only used when in range
  assign in_range = (idx < IDX_W'(NUM_REGS));
  assign access   = sys_wen_i | sys_ren_i;

  //////////////////////////////////////////////////////////////////////
  // registers and answer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      ack_q <= access &  in_range;
      err_q <= access & ~in_range;     // bad index, contents untouched
      if (sys_wen_i && in_range) begin
        for (int b = 0; b < N_BYTES; b++) begin
          if (sys_sel_i[b]) regs_q[word][8*b +: 8] <= sys_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read word, presented together with ack
  always_ff @(posedge clk_i) begin
    if (sys_ren_i && in_range) begin
      rdata_q <= regs_q[word];
    end
  end

  assign sys_rdata_o = rdata_q;
  assign sys_ack_o   = ack_q;
  assign sys_err_o   = err_q;

endmodule

`default_nettype wire

// ==== verilog/sys_bus_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// system bus region decoder for two banks
// unmapped regions answer err one cycle after the strobe
// rdata is only meaningful in the ack cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ps_bus_macros.svh"

module sys_bus_decoder (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // upstream from the bridge
  input  sys_bus_pkg::sys_addr_t sys_addr_i,
  input  sys_bus_pkg::sys_data_t sys_wdata_i,
  input  sys_bus_pkg::sys_sel_t  sys_sel_i,
  input  logic                   sys_wen_i,
  input  logic                   sys_ren_i,
  output sys_bus_pkg::sys_data_t sys_rdata_o,
  output logic                   sys_ack_o,
  output logic                   sys_err_o,
  // bank a
  output logic                   bank_a_wen_o,
  output logic                   bank_a_ren_o,
  input  sys_bus_pkg::sys_data_t bank_a_rdata_i,
  input  logic                   bank_a_ack_i,
  input  logic                   bank_a_err_i,
  // bank b
  output logic                   bank_b_wen_o,
  output logic                   bank_b_ren_o,
  input  sys_bus_pkg::sys_data_t bank_b_rdata_i,
  input  logic                   bank_b_ack_i,
  input  logic                   bank_b_err_i
);

  localparam int REGION_W = `PS_AXI_AW - `SYS_REGION_LSB;

  logic [REGION_W-1:0] region;
  logic                hit_a;
  logic                hit_b;
  logic                unmap_err_q;  // own answer for holes in the map

  assign region = sys_addr_i[`PS_AXI_AW-1:`SYS_REGION_LSB];
  assign hit_a  = (region == `SYS_BANK_A_REGION);
  assign hit_b  = (region == `SYS_BANK_B_REGION);

  // strobes go straight through, same cycle
  assign bank_a_wen_o = sys_wen_i & hit_a;
  assign bank_a_ren_o = sys_ren_i & hit_a;
  assign bank_b_wen_o = sys_wen_i & hit_b;
  assign bank_b_ren_o = sys_ren_i & hit_b;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      unmap_err_q <= 1'b0;
    end else begin
      unmap_err_q <= (sys_wen_i | sys_ren_i) & ~hit_a & ~hit_b;
    end
  end

  // return path, picked by whichever bank acks
  assign sys_rdata_o = bank_a_ack_i ? bank_a_rdata_i :
                       bank_b_ack_i ? bank_b_rdata_i : '0;
  assign sys_ack_o   = bank_a_ack_i | bank_b_ack_i;
  assign sys_err_o   = bank_a_err_i | bank_b_err_i | unmap_err_q;

endmodule

`default_nettype wire

// ==== verilog/axi_slave.sv ====
//////////////////////////////////////////////////////////////////////
// single-beat axi3 slave driving the system bus, one access in flight
// awlen and arlen are not checked, bursts must not be sent
// the bus slave must answer at least one cycle after the strobe
// reads always use all four byte selects
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axi_slave (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // write address channel
  input  axi_pkg::axi_id_t      axi_awid_i,
  input  axi_pkg::axi_addr_t    axi_awaddr_i,
  input  axi_pkg::axi_len_t     axi_awlen_i,    // assumed zero
  input  logic                  axi_awvalid_i,
  output logic                  axi_awready_o,
  // write data channel
  input  axi_pkg::axi_data_t    axi_wdata_i,
  input  axi_pkg::axi_strb_t    axi_wstrb_i,
  input  logic                  axi_wlast_i,    // assumed high, single beat
  input  logic                  axi_wvalid_i,
  output logic                  axi_wready_o,
  // write response channel
  output axi_pkg::axi_id_t      axi_bid_o,
  output axi_pkg::axi_resp_e    axi_bresp_o,
  output logic                  axi_bvalid_o,
  input  logic                  axi_bready_i,
  // read address channel
  input  axi_pkg::axi_id_t      axi_arid_i,
  input  axi_pkg::axi_addr_t    axi_araddr_i,
  input  axi_pkg::axi_len_t     axi_arlen_i,    // assumed zero
  input  logic                  axi_arvalid_i,
  output logic                  axi_arready_o,
  // read data channel
  output axi_pkg::axi_id_t      axi_rid_o,
  output axi_pkg::axi_data_t    axi_rdata_o,
  output axi_pkg::axi_resp_e    axi_rresp_o,
  output logic                  axi_rlast_o,
  output logic                  axi_rvalid_o,
  input  logic                  axi_rready_i,
  // system bus
  output sys_bus_pkg::sys_addr_t sys_addr_o,
  output sys_bus_pkg::sys_data_t sys_wdata_o,
  output sys_bus_pkg::sys_sel_t  sys_sel_o,
  output logic                   sys_wen_o,
  output logic                   sys_ren_o,
  input  sys_bus_pkg::sys_data_t sys_rdata_i,
  input  logic                   sys_ack_i,
  input  logic                   sys_err_i
);

  typedef enum logic [1:0] {
    ST_IDLE,   // readies may go high
    ST_ISSUE,  // strobe on the bus
    ST_WAIT,   // waiting for ack or err
    ST_RESP    // b or r response held
  } state_e;

  state_e                 state_q;
  logic                   wr_q;     // access is a write
  axi_pkg::axi_id_t       id_q;
  sys_bus_pkg::sys_addr_t addr_q;
  sys_bus_pkg::sys_data_t wdata_q;
  sys_bus_pkg::sys_sel_t  sel_q;
  axi_pkg::axi_data_t     rdata_q;
  axi_pkg::axi_resp_e     resp_q;

  logic idle;
  logic wr_both;   // aw and w both offered
  logic wr_acc;
  logic rd_acc;
  logic bus_done;  // slave answered
  logic resp_done;

  //////////////////////////////////////////////////////////////////////
  // acceptance
  //////////////////////////////////////////////////////////////////////

  assign idle    = (state_q == ST_IDLE);
  assign wr_both = axi_awvalid_i & axi_wvalid_i;

  // aw and w taken together, writes win a tie
  assign axi_awready_o = idle & wr_both;
  assign axi_wready_o  = idle & wr_both;
  assign axi_arready_o = idle & ~wr_both;

  assign wr_acc = axi_awready_o;
  assign rd_acc = axi_arready_o & axi_arvalid_i;

  assign bus_done  = (state_q == ST_WAIT) & (sys_ack_i | sys_err_i);
  assign resp_done = (state_q == ST_RESP) & (wr_q ? axi_bready_i : axi_rready_i);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:  if (wr_acc || rd_acc) state_q <= ST_ISSUE;
        ST_ISSUE: state_q <= ST_WAIT;           // strobe lasts one cycle
        ST_WAIT:  if (bus_done) state_q <= ST_RESP;
        ST_RESP:  if (resp_done) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  // request capture on acceptance
  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      wr_q    <= 1'b1;
      id_q    <= axi_awid_i;
      addr_q  <= axi_awaddr_i;
      wdata_q <= axi_wdata_i;
      sel_q   <= axi_wstrb_i;
    end else if (rd_acc) begin
      wr_q    <= 1'b0;
      id_q    <= axi_arid_i;
      addr_q  <= axi_araddr_i;
      sel_q   <= '1;                  // full word read
    end
  end

  // answer capture, held through ST_RESP
  always_ff @(posedge clk_i) begin
    if (bus_done) begin
      rdata_q <= sys_rdata_i;
      resp_q  <= sys_err_i ? axi_pkg::SLVERR : axi_pkg::OKAY;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  assign sys_addr_o  = addr_q;
  assign sys_wdata_o = wdata_q;
  assign sys_sel_o   = sel_q;
  assign sys_wen_o   = (state_q == ST_ISSUE) &  wr_q;
  assign sys_ren_o   = (state_q == ST_ISSUE) & ~wr_q;

  assign axi_bid_o    = id_q;
  assign axi_bresp_o  = resp_q;
  assign axi_bvalid_o = (state_q == ST_RESP) & wr_q;

  assign axi_rid_o    = id_q;
  assign axi_rdata_o  = rdata_q;
  assign axi_rresp_o  = resp_q;
  assign axi_rlast_o  = 1'b1;                        // every read is one beat
  assign axi_rvalid_o = (state_q == ST_RESP) & ~wr_q;

endmodule

`default_nettype wire

// ==== verilog/sys_bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// system bus word types, same widths as the axi side
//////////////////////////////////////////////////////////////////////

`default_nettype none

package sys_bus_pkg;

  `include "ps_bus_macros.svh"

  // strobe bus, one word per access
  typedef logic [`PS_AXI_AW-1:0]   sys_addr_t;
  typedef logic [`PS_AXI_DW-1:0]   sys_data_t;
  typedef logic [`PS_AXI_DW/8-1:0] sys_sel_t;  // byte selects

endpackage

`default_nettype wire

// ==== verilog/axi_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// axi3 field types for the gp slave port
// only OKAY and SLVERR are ever returned
//////////////////////////////////////////////////////////////////////

`default_nettype none

package axi_pkg;

  `include "ps_bus_macros.svh"

  typedef logic [`PS_AXI_IW-1:0]   axi_id_t;    // transaction id
  typedef logic [`PS_AXI_AW-1:0]   axi_addr_t;  // byte address
  typedef logic [`PS_AXI_DW-1:0]   axi_data_t;
  typedef logic [`PS_AXI_DW/8-1:0] axi_strb_t;  // one bit per byte lane
  typedef logic [3:0]              axi_len_t;   // axi3 burst length

  // response codes, EXOKAY and DECERR unused
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

// ==== verilog/ps_bus_macros.svh ====
//////////////////////////////////////////////////////////////////////
// widths and address map of the ps axi to system bus bridge
// region field is addr[31:SYS_REGION_LSB], one bank per region
// bank sizes count 32-bit words, each bank needs at least 2
//////////////////////////////////////////////////////////////////////

`ifndef PS_BUS_MACROS_SVH
`define PS_BUS_MACROS_SVH

// axi gp port widths
`define PS_AXI_DW 32  // data width
`define PS_AXI_AW 32  // address width
`define PS_AXI_IW 12  // id width, same as the gp0 master

// system bus address map
`define SYS_REGION_LSB    20
`define SYS_BANK_A_REGION 12'h400  // 0x4000_0000
`define SYS_BANK_B_REGION 12'h401  // 0x4010_0000

// bank sizes in words
`define SYS_BANK_A_REGS 4
`define SYS_BANK_B_REGS 16

`endif
